//--- Makefile
# Verilator build and run for the SPI to Wishbone bridge

VERILATOR ?= verilator
TOP       ?= spi_wb_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/spi_frame_pkg.sv
// --------------------------------------------------
// SPI frame definitions
// 16-bit frame layout, command and parity views,
// op codes and reply status codes
// --------------------------------------------------
`default_nettype none

package spi_frame_pkg;

  localparam int FRAME_W = 16;

  // Command view of a frame, also used for replies
  typedef struct packed {
    logic [1:0] op;
    logic       par;
    logic [4:0] addr;
    logic [7:0] data;
  } frame_cmd_t;

  // Parity view, par bit folded into the payload
  typedef struct packed {
    logic [1:0]         op;
    logic [FRAME_W-3:0] payload;
  } frame_raw_t;

  typedef union packed {
    frame_cmd_t cmd;
    frame_raw_t raw;
  } spi_frame_u;

  // Op codes, value 3 is reserved and acts as a nop
  localparam logic [1:0] OP_NOP   = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_READ  = 2'd2;

  // Reply status, carried in the op field
  localparam logic [1:0] ST_NONE   = 2'd0;
  localparam logic [1:0] ST_WROTE  = 2'd1;
  localparam logic [1:0] ST_READ   = 2'd2;
  localparam logic [1:0] ST_PARITY = 2'd3;

endpackage

`default_nettype wire

//--- rtl/spi_minion.sv
// --------------------------------------------------
// SPI mode 0 minion
// Shifts frames in on sclk rise and out on sclk fall,
// pushes on cs_n rise and pulls on cs_n fall
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_minion #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sclk,
  input  logic                      cs_n,
  input  logic                      mosi,
  output logic                      miso,
  output logic                      push_en,
  output spi_frame_pkg::spi_frame_u push_frame,
  output logic                      push_parity_ok,
  output logic                      pull_en,
  input  spi_frame_pkg::spi_frame_u reply_frame
);

  import spi_frame_pkg::*;

  logic               cs_level;
  logic               cs_rise;
  logic               cs_fall;
  logic               sclk_rise;
  logic               sclk_fall;
  logic               mosi_level;
  logic               shift_in;
  logic               shift_out;
  logic [FRAME_W-1:0] rx_q;
  logic [FRAME_W-1:0] tx_q;

  // --------------------------------------------------
  // Pin synchronizers
  // --------------------------------------------------
  // cs_n idles high, so its chain starts high
  spi_synchronizer #(.SYNC_STAGES(SYNC_STAGES), .RESET_VAL(1'b1)) u_cs_sync (
    .clk(clk), .arst_n(arst_n), .sig(cs_n),
    .level(cs_level), .rise(cs_rise), .fall(cs_fall)
  );

  spi_synchronizer #(.SYNC_STAGES(SYNC_STAGES), .RESET_VAL(1'b0)) u_sclk_sync (
    .clk(clk), .arst_n(arst_n), .sig(sclk),
    .level(), .rise(sclk_rise), .fall(sclk_fall)
  );

  spi_synchronizer #(.SYNC_STAGES(SYNC_STAGES), .RESET_VAL(1'b0)) u_mosi_sync (
    .clk(clk), .arst_n(arst_n), .sig(mosi),
    .level(mosi_level), .rise(), .fall()
  );

  // --------------------------------------------------
  // Shift registers
  // --------------------------------------------------
  assign shift_in  = ~cs_level & sclk_rise;
  assign shift_out = ~cs_level & sclk_fall;

  always_ff @(posedge clk) begin
    if (shift_in) begin
      rx_q <= {rx_q[FRAME_W-2:0], mosi_level};
    end
  end

  // Reply loads as the frame opens, MSB first on miso
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_q <= '0;
    end else if (pull_en) begin
      tx_q <= reply_frame;
    end else if (shift_out) begin
      tx_q <= {tx_q[FRAME_W-2:0], 1'b0};
    end
  end

  assign miso           = tx_q[FRAME_W-1];
  assign push_en        = cs_rise;
  assign pull_en        = cs_fall;
  assign push_frame     = rx_q;
  // Even parity over the payload view
  assign push_parity_ok = ~(^push_frame.raw.payload);

endmodule

`default_nettype wire

//--- rtl/spi_synchronizer.sv
// --------------------------------------------------
// SPI pin synchronizer
// Flop chain plus history flop, gives the level
// and one-cycle rise and fall strobes
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_synchronizer #(
  parameter int   SYNC_STAGES = 2,
  parameter logic RESET_VAL   = 1'b0
) (
  input  logic clk,
  input  logic arst_n,
  input  logic sig,
  output logic level,
  output logic rise,
  output logic fall
);

  logic [SYNC_STAGES-1:0] chain_q;
  logic                   hist_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chain_q <= {SYNC_STAGES{RESET_VAL}};
      hist_q  <= RESET_VAL;
    end else begin
      chain_q[0] <= sig;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
      hist_q <= chain_q[SYNC_STAGES-1];
    end
  end

  assign level = chain_q[SYNC_STAGES-1];
  assign rise  = level & ~hist_q;
  assign fall  = ~level & hist_q;

endmodule

`default_nettype wire

//--- rtl/spi_wb_master.sv
// --------------------------------------------------
// SPI command to Wishbone master
// Decodes pushed frames, runs one classic cycle
// and holds the reply for the next frame
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_wb_master (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      push_en,
  input  spi_frame_pkg::spi_frame_u push_frame,
  input  logic                      push_parity_ok,
  output spi_frame_pkg::spi_frame_u reply_frame,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output wb_bus_pkg::wb_addr_t      wb_adr,
  output wb_bus_pkg::wb_data_t      wb_dat_w,
  input  logic                      wb_ack,
  input  wb_bus_pkg::wb_data_t      wb_dat_r
);

  import spi_frame_pkg::*;
  import wb_bus_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_BUS
  } state_t;

  state_t     state;
  logic       stb_q;
  spi_frame_u reply_q;
  logic       we_q;
  wb_addr_t   adr_q;
  wb_data_t   dat_q;
  logic       is_rw;
  logic       start;

  assign is_rw = (push_frame.cmd.op == OP_WRITE) || (push_frame.cmd.op == OP_READ);
  // Frames arriving during an open cycle are dropped
  assign start = (state == S_IDLE) && push_en && push_parity_ok && is_rw;

  // --------------------------------------------------
  // Controller and reply register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= S_IDLE;
      stb_q   <= 1'b0;
      reply_q.cmd <= '{op: ST_NONE, par: 1'b0, addr: '0, data: '0};
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_BUS;
            stb_q <= 1'b1;
          end else if (push_en && !push_parity_ok) begin
            reply_q.cmd <= '{op: ST_PARITY, par: 1'b0,
                             addr: push_frame.cmd.addr, data: push_frame.cmd.data};
          end
        end
        S_BUS: begin
          if (wb_ack) begin
            state <= S_IDLE;
            stb_q <= 1'b0;
            reply_q.cmd <= '{op: we_q ? ST_WROTE : ST_READ, par: 1'b0,
                             addr: adr_q, data: we_q ? dat_q : wb_dat_r};
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Bus request fields, captured when a cycle opens
  always_ff @(posedge clk) begin
    if (start) begin
      we_q  <= (push_frame.cmd.op == OP_WRITE);
      adr_q <= push_frame.cmd.addr;
      dat_q <= push_frame.cmd.data;
    end
  end

  assign wb_cyc      = (state == S_BUS);
  assign wb_stb      = stb_q;
  assign wb_we       = we_q;
  assign wb_adr      = adr_q;
  assign wb_dat_w    = dat_q;
  assign reply_frame = reply_q;

endmodule

`default_nettype wire

//--- rtl/spi_wb_top.sv
// --------------------------------------------------
// SPI to Wishbone register bridge
// Minion, command master and register file
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_wb_top #(
  parameter int REG_DEPTH   = 16,
  parameter int SYNC_STAGES = 2
) (
  input  logic clk,
  input  logic arst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  import spi_frame_pkg::*;
  import wb_bus_pkg::*;

  // Minion to master
  logic       push_en;
  spi_frame_u push_frame;
  logic       push_parity_ok;
  logic       pull_en;
  spi_frame_u reply_frame;

  // Wishbone
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  logic     wb_ack;
  wb_data_t wb_dat_r;

  spi_minion #(.SYNC_STAGES(SYNC_STAGES)) u_minion (
    .clk(clk), .arst_n(arst_n),
    .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .push_en(push_en), .push_frame(push_frame), .push_parity_ok(push_parity_ok),
    .pull_en(pull_en), .reply_frame(reply_frame)
  );

  spi_wb_master u_master (
    .clk(clk), .arst_n(arst_n),
    .push_en(push_en), .push_frame(push_frame), .push_parity_ok(push_parity_ok),
    .reply_frame(reply_frame),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
  );

  wb_regfile #(.REG_DEPTH(REG_DEPTH)) u_regfile (
    .clk(clk), .arst_n(arst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
  );

endmodule

`default_nettype wire

//--- rtl/wb_bus_pkg.sv
// --------------------------------------------------
// Wishbone bus definitions
// Address and data widths of the register bus
// --------------------------------------------------
`default_nettype none

package wb_bus_pkg;

  localparam int WB_ADDR_W = 5;
  localparam int WB_DATA_W = 8;

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [WB_DATA_W-1:0] wb_data_t;

endpackage

`default_nettype wire

//--- rtl/wb_regfile.sv
// --------------------------------------------------
// Wishbone classic register file
// REG_DEPTH byte registers, registered ack,
// addresses past the end read as zero
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_regfile #(
  parameter int REG_DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  wb_bus_pkg::wb_addr_t wb_adr,
  input  wb_bus_pkg::wb_data_t wb_dat_w,
  output logic                 wb_ack,
  output wb_bus_pkg::wb_data_t wb_dat_r
);

  import wb_bus_pkg::*;

  localparam int IDX_W = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;

  wb_data_t           regs [REG_DEPTH];
  logic               req;
  logic               in_range;
  logic [IDX_W-1:0]   idx;

  // One request per cycle, ack closes it
  assign req      = wb_cyc & wb_stb & ~wb_ack;
  assign in_range = (int'(wb_adr) < REG_DEPTH);
  assign idx      = wb_adr[IDX_W-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
      for (int i = 0; i < REG_DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else begin
      wb_ack <= req;
      if (req && wb_we && in_range) begin
        regs[idx] <= wb_dat_w;
      end
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= in_range ? regs[idx] : '0;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
rtl/spi_frame_pkg.sv
rtl/wb_bus_pkg.sv
rtl/spi_synchronizer.sv
rtl/spi_minion.sv
rtl/spi_wb_master.sv
rtl/wb_regfile.sv
rtl/spi_wb_top.sv
tests/spi_wb_assertions.sv
tests/spi_wb_tb.sv

//--- tests/spi_wb_assertions.sv
// --------------------------------------------------
// Bridge protocol assertions
// Wishbone classic handshake, push timing and
// miso level during reset
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_wb_assertions (
  input logic clk,
  input logic arst_n,
  input logic miso,
  input logic push_en,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack
);

  // Failure tally, read by the testbench
  int fail_count = 0;

  // --------------------------------------------------
  // Wishbone classic
  // --------------------------------------------------
  a_stb_is_cyc: assert property (@(posedge clk) disable iff (!arst_n)
    wb_stb == wb_cyc)
  else begin
    fail_count++;
    $error("wb_stb differs from wb_cyc");
  end

  a_ack_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |-> wb_cyc)
  else begin
    fail_count++;
    $error("wb_ack seen outside a bus cycle");
  end

  a_cyc_until_ack: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_cyc && !wb_ack) |=> wb_cyc)
  else begin
    fail_count++;
    $error("wb_cyc dropped before wb_ack");
  end

  // --------------------------------------------------
  // Minion side
  // --------------------------------------------------
  // No frame may be pushed into an open cycle
  a_push_idle: assert property (@(posedge clk) disable iff (!arst_n)
    push_en |-> !wb_cyc)
  else begin
    fail_count++;
    $error("push_en arrived during an open bus cycle");
  end

  a_miso_reset: assert property (@(posedge clk)
    !arst_n |-> !miso)
  else begin
    fail_count++;
    $error("miso not low during reset");
  end

endmodule

bind spi_wb_top spi_wb_assertions u_assert (
  .clk(clk),
  .arst_n(arst_n),
  .miso(miso),
  .push_en(push_en),
  .wb_cyc(wb_cyc),
  .wb_stb(wb_stb),
  .wb_ack(wb_ack)
);

`default_nettype wire

//--- tests/spi_wb_tb.sv
// --------------------------------------------------
// SPI to Wishbone bridge testbench
// Drives SPI mode 0 frames, models the register
// file and checks every reply shifted out on miso
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_wb_tb;

  import spi_frame_pkg::*;

  localparam int REG_DEPTH   = 16;
  localparam int SYNC_STAGES = 2;
  localparam int IDX_W       = $clog2(REG_DEPTH);
  localparam int CLK_PERIOD  = 40;
  // sclk half period in clk periods
  localparam int HALF_SCLK   = 5;
  localparam int N_FRAMES    = 60;
  localparam int TIMEOUT_NS  = N_FRAMES * 20 * (2 * HALF_SCLK * CLK_PERIOD) + 20000;

  logic        clk;
  logic        arst_n;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  logic [7:0]  model_regs [REG_DEPTH];
  logic [15:0] exp_reply;
  int          seed = 55431;
  int          checks = 0;
  int          errors = 0;

  spi_wb_top #(.REG_DEPTH(REG_DEPTH), .SYNC_STAGES(SYNC_STAGES)) uut (
    .clk(clk), .arst_n(arst_n),
    .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Simulation timed out after %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Even parity over par, addr and data
  function automatic logic [15:0] build_frame(input logic [1:0] op, input logic [4:0] addr,
                                              input logic [7:0] data, input logic corrupt);
    spi_frame_u f;
    f.cmd.op   = op;
    f.cmd.addr = addr;
    f.cmd.data = data;
    f.cmd.par  = (^{addr, data}) ^ corrupt;
    return f;
  endfunction

  // One mode 0 frame, MSB first, miso captured on each sclk rise
  task automatic shift_frame(input logic [15:0] tx, output logic [15:0] rx);
    cs_n = 1'b0;
    wait_clocks(HALF_SCLK);
    for (int i = 15; i >= 0; i--) begin
      mosi = tx[i];
      wait_clocks(HALF_SCLK);
      sclk  = 1'b1;
      rx[i] = miso;
      wait_clocks(HALF_SCLK);
      sclk = 1'b0;
    end
    wait_clocks(HALF_SCLK);
    cs_n = 1'b1;
    mosi = 1'b0;
    // Bus transaction settles well inside this gap
    wait_clocks(2 * HALF_SCLK);
  endtask

  // Sends a frame, checks the reply of the previous one, updates the model
  task automatic run_frame(input string name, input logic [1:0] op, input logic [4:0] addr,
                           input logic [7:0] data, input logic corrupt);
    logic [15:0] rx;
    logic [15:0] expected;
    logic [7:0]  rd_data;
    expected = exp_reply;
    shift_frame(build_frame(op, addr, data, corrupt), rx);
    check_value(name, expected, rx);
    if (corrupt) begin
      exp_reply = {ST_PARITY, 1'b0, addr, data};
    end else if (op == OP_WRITE) begin
      if (int'(addr) < REG_DEPTH) begin
        model_regs[addr[IDX_W-1:0]] = data;
      end
      exp_reply = {ST_WROTE, 1'b0, addr, data};
    end else if (op == OP_READ) begin
      rd_data   = (int'(addr) < REG_DEPTH) ? model_regs[addr[IDX_W-1:0]] : 8'h00;
      exp_reply = {ST_READ, 1'b0, addr, rd_data};
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [1:0] op;
    logic [4:0] addr;
    logic [7:0] data;
    arst_n    = 1'b0;
    sclk      = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    exp_reply = '0;
    for (int i = 0; i < REG_DEPTH; i++) begin
      model_regs[i] = 8'h00;
    end
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    wait_clocks(5);

    run_frame("reset_reply", OP_READ, 5'd0, 8'h00, 1'b0);

    // Write then read back
    run_frame("before_write", OP_WRITE, 5'd3, 8'hA5, 1'b0);
    run_frame("write_reply", OP_READ, 5'd3, 8'h00, 1'b0);
    run_frame("read_reply", OP_NOP, 5'd0, 8'h00, 1'b0);

    // Bad parity, register must keep A5
    run_frame("before_parity", OP_WRITE, 5'd3, 8'h5A, 1'b1);
    run_frame("parity_reply", OP_READ, 5'd3, 8'h00, 1'b0);
    run_frame("after_parity", OP_NOP, 5'd0, 8'h00, 1'b0);

    // Past the end of the register file
    run_frame("before_oob", OP_WRITE, 5'd20, 8'h77, 1'b0);
    run_frame("oob_write_reply", OP_READ, 5'd20, 8'h00, 1'b0);
    // Register sharing the low address bits must not see that write
    run_frame("oob_read_reply", OP_READ, 5'(20 % REG_DEPTH), 8'h00, 1'b0);

    // Nop keeps the previous reply
    run_frame("before_nop", OP_READ, 5'd3, 8'h00, 1'b0);
    run_frame("nop_first", OP_NOP, 5'd0, 8'h00, 1'b0);
    run_frame("nop_repeat", 2'd3, 5'd9, 8'h3C, 1'b0);

    // Every address gets a write and a read, then a random tail
    for (int i = 0; i < 40; i++) begin
      if (i < 2 * REG_DEPTH) begin
        op   = (i % 2 == 0) ? OP_WRITE : OP_READ;
        addr = 5'(i / 2);
      end else begin
        op   = (($random(seed) & 1) != 0) ? OP_WRITE : OP_READ;
        addr = 5'($random(seed));
      end
      data = 8'($random(seed));
      run_frame($sformatf("random_%0d", i), op, addr, data, 1'b0);
    end
    run_frame("random_last", OP_NOP, 5'd0, 8'h00, 1'b0);

    $display("Checks: %0d, value errors: %0d, assertion errors: %0d",
             checks, errors, uut.u_assert.fail_count);
    if (errors == 0 && uut.u_assert.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
